// ==== cpu_pkg.sv ====
// 64-bit core with 256-word memories; pc and data addresses wrap modulo 256, no byte enables
`default_nettype none

package cpu_pkg;

  localparam int XLEN    = 64;
  localparam int ILEN    = 32;
  localparam int REG_AW  = 5;
  localparam int MEM_AW  = 8;
  localparam int IMM_W   = 16;
  localparam int PADDR_W = 16;
  localparam int OFFS_W  = PADDR_W - 2;

  // paddr[15:14] picks the region
  localparam logic [1:0] REGION_CTRL = 2'b00;
  localparam logic [1:0] REGION_REG  = 2'b01;
  localparam logic [1:0] REGION_IMEM = 2'b10;
  localparam logic [1:0] REGION_DMEM = 2'b11;

  // control region offsets
  localparam logic [OFFS_W-1:0] CTRL_RUN     = 14'd0;
  localparam logic [OFFS_W-1:0] CTRL_RETIRED = 14'd1;

  typedef enum logic [5:0] {
    OP_NOOP = 6'b000000,
    OP_ADD  = 6'b000100,
    OP_AND  = 6'b100100,
    OP_CMP  = 6'b111100,
    OP_LW   = 6'b001011,
    OP_SW   = 6'b001100,
    OP_JA   = 6'b001111,
    OP_HALT = 6'b111111
  } opcode_e;

  typedef logic [XLEN-1:0]   data_t;
  typedef logic [REG_AW-1:0] reg_idx_t;
  typedef logic [MEM_AW-1:0] mem_addr_t;

  // rd is source and destination
  typedef struct packed {
    opcode_e            op;
    reg_idx_t           rd;
    reg_idx_t           rt;
    logic [IMM_W-1:0]   imm;
  } instr_t;

  typedef struct packed {
    logic reg_we;
    logic mem_re;
    logic mem_we;
    logic use_and;
    logic b_from_reg;
    logic branch;
    logic halt;
  } ctrl_t;

  typedef struct packed {
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [PADDR_W-1:0] paddr;
    data_t              pwdata;
  } apb_req_t;

  typedef struct packed {
    data_t prdata;
    logic  pready;
    logic  pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic      en;
    logic      we;
    mem_addr_t addr;
    data_t     wdata;
  } dmem_req_t;

endpackage

`default_nettype wire

// ==== word_ram.sv ====
// single-port RAM of 256 words, one-cycle read latency; rdata holds while en is low
`timescale 1ns/1ps
`default_nettype none

module word_ram
  import cpu_pkg::*;
#(
  parameter type word_t = data_t
) (
  input  logic      clk,
  input  logic      en,
  input  logic      we,
  input  mem_addr_t addr,
  input  word_t     wdata,
  output word_t     rdata
);

  word_t mem [2**MEM_AW];

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end else begin
        rdata <= mem[addr];
      end
    end
  end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
// 32x64 register file, reads are combinational; entry 0 is never written so it reads as zero
`timescale 1ns/1ps
`default_nettype none

module reg_file
  import cpu_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rd_addr,
  input  reg_idx_t rt_addr,
  input  reg_idx_t dbg_addr,
  output data_t    rd_data,
  output data_t    rt_data,
  output data_t    dbg_data,
  input  logic     wb_en,
  input  reg_idx_t wb_addr,
  input  data_t    wb_data
);

  data_t regs [2**REG_AW];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**REG_AW; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en) begin
      regs[wb_addr] <= wb_data;
    end
  end

  assign rd_data  = regs[rd_addr];
  assign rt_data  = regs[rt_addr];
  // host readback port
  assign dbg_data = regs[dbg_addr];

  // the sequencer must filter rd == 0
  a_no_r0_write: assert property (@(posedge clk) disable iff (rst)
    wb_en |-> wb_addr != '0);

endmodule

`default_nettype wire

// ==== exec_unit.sv ====
// combinational alu; add wraps at 64 bits, the immediate is always sign-extended
`timescale 1ns/1ps
`default_nettype none

module exec_unit
  import cpu_pkg::*;
(
  input  data_t            a,
  input  data_t            rt_data,
  input  logic [IMM_W-1:0] imm,
  input  ctrl_t            ctrl,
  output data_t            result,
  output logic             eq
);

  data_t imm_ext;
  data_t b;

  assign imm_ext = {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};
  // lw and sw take rd + imm as address
  assign b       = ctrl.b_from_reg ? rt_data : imm_ext;
  assign result  = ctrl.use_and ? (a & b) : (a + b);
  assign eq      = a == rt_data;

endmodule

`default_nettype wire

// ==== instr_seq.sv ====
// multi-cycle sequencer, 2 cycles per instruction and 3 for lw; unknown opcodes run as noop
`timescale 1ns/1ps
`default_nettype none

module instr_seq
  import cpu_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  output logic             running,
  output logic             retire,
  output logic             imem_en,
  output mem_addr_t        imem_addr,
  input  instr_t           instr,
  output reg_idx_t         rd_addr,
  output reg_idx_t         rt_addr,
  output ctrl_t            ctrl,
  output logic [IMM_W-1:0] imm,
  input  logic             eq,
  output dmem_req_t        dmem,
  input  data_t            alu_result,
  input  data_t            rt_data,
  output logic             wb_en,
  output reg_idx_t         wb_addr,
  output logic             wb_sel_mem
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_FETCH,
    S_EXEC,
    S_MEM
  } state_e;

  state_e    state;
  mem_addr_t pc;
  mem_addr_t pc_next;
  ctrl_t     dec;
  logic      in_exec;
  logic      done;

  always_comb begin
    case (instr.op)
      OP_ADD:  dec = '{reg_we: 1'b1, b_from_reg: 1'b1, default: 1'b0};
      OP_AND:  dec = '{reg_we: 1'b1, use_and: 1'b1, b_from_reg: 1'b1, default: 1'b0};
      OP_CMP:  dec = '{branch: 1'b1, b_from_reg: 1'b1, default: 1'b0};
      OP_JA:   dec = '{branch: 1'b1, b_from_reg: 1'b1, default: 1'b0};
      OP_LW:   dec = '{reg_we: 1'b1, mem_re: 1'b1, default: 1'b0};
      OP_SW:   dec = '{mem_we: 1'b1, default: 1'b0};
      OP_HALT: dec = '{halt: 1'b1, default: 1'b0};
      default: dec = '0;
    endcase
  end

  assign in_exec = state == S_EXEC;
  // instruction completes here, lw one cycle later
  assign done    = (in_exec && !dec.mem_re) || state == S_MEM;

  // halt drops running in its own execute cycle
  assign running = state != S_IDLE && !(in_exec && dec.halt);
  assign retire  = done;

  assign imem_en   = state == S_FETCH;
  assign imem_addr = pc;
  assign rd_addr   = instr.rd;
  assign rt_addr   = instr.rt;
  assign imm       = instr.imm;
  assign ctrl      = (in_exec || state == S_MEM) ? dec : '0;

  assign dmem.en    = in_exec && (dec.mem_re || dec.mem_we);
  assign dmem.we    = in_exec && dec.mem_we;
  assign dmem.addr  = alu_result[MEM_AW-1:0];
  assign dmem.wdata = rt_data;

  assign wb_en      = done && dec.reg_we && instr.rd != '0;
  assign wb_addr    = instr.rd;
  assign wb_sel_mem = state == S_MEM;

  // branch target pc + 1 + imm, wraps with the imem size
  assign pc_next = (dec.branch && eq) ? pc + mem_addr_t'(1) + instr.imm[MEM_AW-1:0]
                                      : pc + mem_addr_t'(1);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_IDLE;
      pc    <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            state <= S_FETCH;
            pc    <= '0;
          end
        end
        S_FETCH: state <= S_EXEC;
        S_EXEC: begin
          pc <= pc_next;
          if (dec.halt) begin
            state <= S_IDLE;
          end else if (dec.mem_re) begin
            state <= S_MEM;
          end else begin
            state <= S_FETCH;
          end
        end
        default: state <= S_FETCH;
      endcase
    end
  end

  a_mem_excl: assert property (@(posedge clk) disable iff (rst)
    !(ctrl.mem_re && ctrl.mem_we));

endmodule

`default_nettype wire

// ==== apb_host_port.sv ====
// APB slave; memory and register regions only reachable while stopped, memory reads add one wait
`timescale 1ns/1ps
`default_nettype none

module apb_host_port
  import cpu_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  apb_req_t  apb_req,
  output apb_rsp_t  apb_rsp,
  input  logic      running,
  input  logic      retire,
  output logic      start,
  output reg_idx_t  dbg_addr,
  input  data_t     dbg_data,
  input  logic      core_imem_en,
  input  mem_addr_t core_imem_addr,
  input  dmem_req_t core_dmem,
  output logic      imem_en,
  output logic      imem_we,
  output mem_addr_t imem_addr,
  output instr_t    imem_wdata,
  input  instr_t    imem_rdata,
  output dmem_req_t dmem,
  input  data_t     dmem_rdata
);

  logic [1:0]        region;
  logic [OFFS_W-1:0] offset;
  logic              access;
  logic              host_ok;
  logic              mem_sel;
  logic              rd_wait;
  logic              rd_pend;
  logic              host_imem_en;
  logic              host_imem_we;
  dmem_req_t         host_dmem;
  data_t             retired;

  assign region   = apb_req.paddr[PADDR_W-1:PADDR_W-2];
  assign offset   = apb_req.paddr[OFFS_W-1:0];
  assign access   = apb_req.psel && apb_req.penable;
  assign host_ok  = access && !running;
  assign mem_sel  = region == REGION_IMEM || region == REGION_DMEM;
  // first access cycle of a memory read, the RAM answers next cycle
  assign rd_wait  = host_ok && mem_sel && !apb_req.pwrite && !rd_pend;
  assign dbg_addr = apb_req.paddr[REG_AW-1:0];

  // control writes are zero-wait so this is a single-cycle pulse
  assign start = access && apb_req.pwrite && region == REGION_CTRL &&
                 offset == CTRL_RUN && apb_req.pwdata[0] && !running;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_pend <= 1'b0;
    end else begin
      rd_pend <= rd_wait;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || start) begin
      retired <= '0;
    end else if (retire) begin
      retired <= retired + 1'b1;
    end
  end

  // host side of the RAM ports
  assign host_imem_en    = host_ok && region == REGION_IMEM && (apb_req.pwrite || !rd_pend);
  assign host_imem_we    = host_ok && region == REGION_IMEM && apb_req.pwrite;
  assign host_dmem.en    = host_ok && region == REGION_DMEM && (apb_req.pwrite || !rd_pend);
  assign host_dmem.we    = host_ok && region == REGION_DMEM && apb_req.pwrite;
  assign host_dmem.addr  = apb_req.paddr[MEM_AW-1:0];
  assign host_dmem.wdata = apb_req.pwdata;
  assign imem_wdata      = instr_t'(apb_req.pwdata[ILEN-1:0]);

  always_comb begin
    if (running) begin
      imem_en   = core_imem_en;
      imem_we   = 1'b0;
      imem_addr = core_imem_addr;
      dmem      = core_dmem;
    end else begin
      imem_en   = host_imem_en;
      imem_we   = host_imem_we;
      imem_addr = apb_req.paddr[MEM_AW-1:0];
      dmem      = host_dmem;
    end
  end

  always_comb begin
    apb_rsp.pready  = !rd_wait;
    apb_rsp.pslverr = access && running && region != REGION_CTRL;
    apb_rsp.prdata  = '0;
    if (!apb_rsp.pslverr) begin
      case (region)
        REGION_CTRL: begin
          if (offset == CTRL_RUN) begin
            apb_rsp.prdata = data_t'(!running);
          end else if (offset == CTRL_RETIRED) begin
            apb_rsp.prdata = retired;
          end
        end
        REGION_REG:  apb_rsp.prdata = dbg_data;
        REGION_IMEM: apb_rsp.prdata = data_t'(imem_rdata);
        default:     apb_rsp.prdata = dmem_rdata;
      endcase
    end
  end

  // a wait state lasts exactly one cycle and only inside an access phase
  a_one_wait: assert property (@(posedge clk) disable iff (rst)
    !apb_rsp.pready |-> access ##1 apb_rsp.pready);

  // any RAM write not issued by the core comes from a host write access while stopped
  a_no_host_write: assert property (@(posedge clk) disable iff (rst)
    (imem_we || (dmem.we && !core_dmem.we)) |->
      !running && access && apb_req.pwrite && mem_sel);

endmodule

`default_nettype wire

// ==== cpu_top.sv ====
// core wrapper; the only external access is the APB port, memories start undefined until loaded
`timescale 1ns/1ps
`default_nettype none

module cpu_top
  import cpu_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp
);

  logic             start;
  logic             running;
  logic             retire;
  reg_idx_t         dbg_addr;
  data_t            dbg_data;
  logic             core_imem_en;
  mem_addr_t        core_imem_addr;
  dmem_req_t        core_dmem;
  logic             imem_en;
  logic             imem_we;
  mem_addr_t        imem_addr;
  instr_t           imem_wdata;
  instr_t           imem_rdata;
  dmem_req_t        dmem_req;
  data_t            dmem_rdata;
  reg_idx_t         rd_addr;
  reg_idx_t         rt_addr;
  data_t            rd_data;
  data_t            rt_data;
  ctrl_t            ctrl;
  logic [IMM_W-1:0] imm;
  logic             eq;
  data_t            alu_result;
  logic             wb_en;
  reg_idx_t         wb_addr;
  logic             wb_sel_mem;
  data_t            wb_data;

  // lw takes its value from dmem, everything else from the alu
  assign wb_data = wb_sel_mem ? dmem_rdata : alu_result;

  apb_host_port u_host (
    .clk, .rst, .apb_req, .apb_rsp, .running, .retire, .start,
    .dbg_addr, .dbg_data, .core_imem_en, .core_imem_addr, .core_dmem,
    .imem_en, .imem_we, .imem_addr, .imem_wdata, .imem_rdata,
    .dmem(dmem_req), .dmem_rdata
  );

  instr_seq u_seq (
    .clk, .rst, .start, .running, .retire,
    .imem_en(core_imem_en), .imem_addr(core_imem_addr), .instr(imem_rdata),
    .rd_addr, .rt_addr, .ctrl, .imm, .eq, .dmem(core_dmem),
    .alu_result, .rt_data, .wb_en, .wb_addr, .wb_sel_mem
  );

  exec_unit u_exec (
    .a(rd_data), .rt_data, .imm, .ctrl, .result(alu_result), .eq
  );

  reg_file u_regs (
    .clk, .rst, .rd_addr, .rt_addr, .dbg_addr, .rd_data, .rt_data, .dbg_data,
    .wb_en, .wb_addr, .wb_data
  );

  word_ram #(.word_t(instr_t)) u_imem (
    .clk, .en(imem_en), .we(imem_we), .addr(imem_addr),
    .wdata(imem_wdata), .rdata(imem_rdata)
  );

  word_ram #(.word_t(data_t)) u_dmem (
    .clk, .en(dmem_req.en), .we(dmem_req.we), .addr(dmem_req.addr),
    .wdata(dmem_req.wdata), .rdata(dmem_rdata)
  );

endmodule

`default_nettype wire

// ==== tb_tests.svh ====
// directed tests of tb_top; run in order, test_run_ctrl needs r12 as left by test_branch
instr_t prog[$];
data_t  eq_val;

function automatic instr_t encode(opcode_e op, int rd, int rt, int imm);
  instr_t i;
  i.op  = op;
  i.rd  = reg_idx_t'(rd);
  i.rt  = reg_idx_t'(rt);
  i.imm = IMM_W'(imm);
  return i;
endfunction

// base plus sign-extended imm, wrapped to 256 words
function automatic int wrap_addr(data_t base, int imm);
  data_t sum;
  sum = base + data_t'(imm);
  return int'(sum[MEM_AW-1:0]);
endfunction

task automatic write_ok(input logic [PADDR_W-1:0] addr, input data_t data);
  logic err;
  apb_write(addr, data, err);
  check_status($sformatf("write to %h", addr), err, 1'b0);
endtask

task automatic read_ok(input logic [PADDR_W-1:0] addr, output data_t data);
  logic err;
  apb_read(addr, data, err);
  check_status($sformatf("read of %h", addr), err, 1'b0);
endtask

task automatic load_program();
  foreach (prog[i]) write_ok(imem_at(i), data_t'(prog[i]));
endtask

task automatic start_core();
  write_ok(ctrl_at(CTRL_RUN), data_t'(1));
endtask

task automatic wait_stopped();
  data_t st;
  int    polls;
  st    = '0;
  polls = 0;
  while (st[0] !== 1'b1 && polls < 100) begin
    read_ok(ctrl_at(CTRL_RUN), st);
    polls++;
  end
  if (st[0] !== 1'b1) begin
    $display("core still running after %0d status polls", polls);
    count_error();
  end
endtask

task automatic test_reset();
  data_t  val;
  instr_t words [8];
  test_errs = 0;
  read_ok(ctrl_at(CTRL_RUN), val);
  check_flag("CTRL_RUN stopped bit", val[0], 1'b1);
  read_ok(ctrl_at(CTRL_RETIRED), val);
  check_data("CTRL_RETIRED", val, '0);
  for (int r = 0; r < 32; r++) begin
    read_ok(reg_at(r), val);
    check_data($sformatf("r%0d", r), val, '0);
  end
  for (int k = 0; k < 8; k++) begin
    words[k] = instr_t'(lcg_next());
    write_ok(imem_at(k * 31 + 3), data_t'(words[k]));
  end
  for (int k = 0; k < 8; k++) begin
    read_ok(imem_at(k * 31 + 3), val);
    check_word($sformatf("imem[%0d]", k * 31 + 3), instr_t'(val[ILEN-1:0]), words[k]);
  end
  finish_test("reset");
endtask

task automatic test_arith();
  data_t a;
  data_t b;
  data_t val;
  test_errs = 0;
  a = rand64();
  b = rand64();
  write_ok(dmem_at(10), a);
  write_ok(dmem_at(11), b);
  prog.delete();
  prog.push_back(encode(OP_LW, 1, 0, 10));
  prog.push_back(encode(OP_LW, 2, 0, 11));
  prog.push_back(encode(OP_ADD, 3, 1, 0));
  prog.push_back(encode(OP_ADD, 3, 2, 0));
  prog.push_back(encode(OP_ADD, 4, 1, 0));
  prog.push_back(encode(OP_AND, 4, 2, 0));
  prog.push_back(encode(OP_ADD, 0, 1, 0));
  prog.push_back(encode(OP_SW, 0, 3, 20));
  prog.push_back(encode(OP_SW, 0, 4, 21));
  prog.push_back(encode(OP_HALT, 0, 0, 0));
  load_program();
  start_core();
  wait_stopped();
  read_ok(reg_at(1), val);
  check_data("r1", val, a);
  read_ok(reg_at(2), val);
  check_data("r2", val, b);
  read_ok(reg_at(3), val);
  check_data("r3 sum", val, a + b);
  read_ok(reg_at(4), val);
  check_data("r4 and", val, a & b);
  read_ok(reg_at(0), val);
  check_data("r0", val, '0);
  read_ok(dmem_at(20), val);
  check_data("dmem[20]", val, a + b);
  read_ok(dmem_at(21), val);
  check_data("dmem[21]", val, a & b);
  read_ok(ctrl_at(CTRL_RETIRED), val);
  check_data("CTRL_RETIRED", val, data_t'(prog.size()));
  finish_test("arith");
endtask

task automatic test_memory();
  data_t v;
  data_t base;
  data_t val;
  test_errs = 0;
  v    = rand64();
  base = data_t'(200);
  write_ok(dmem_at(wrap_addr('0, -6)), v);
  write_ok(dmem_at(wrap_addr('0, -5)), base);
  prog.delete();
  prog.push_back(encode(OP_LW, 5, 0, -6));
  prog.push_back(encode(OP_LW, 6, 0, -5));
  prog.push_back(encode(OP_SW, 0, 5, 300));
  prog.push_back(encode(OP_SW, 6, 5, 70));
  // same word as the store above, reached from the other side
  prog.push_back(encode(OP_LW, 7, 0, -242));
  prog.push_back(encode(OP_SW, 6, 5, -210));
  prog.push_back(encode(OP_HALT, 0, 0, 0));
  load_program();
  start_core();
  wait_stopped();
  read_ok(reg_at(5), val);
  check_data("r5", val, v);
  read_ok(reg_at(6), val);
  check_data("r6", val, base);
  read_ok(reg_at(7), val);
  check_data("r7", val, v);
  read_ok(dmem_at(wrap_addr('0, 300)), val);
  check_data("dmem at 0+300", val, v);
  read_ok(dmem_at(wrap_addr(base, 70)), val);
  check_data("dmem at 200+70", val, v);
  read_ok(dmem_at(wrap_addr(base, -210)), val);
  check_data("dmem at 200-210", val, v);
  finish_test("memory");
endtask

task automatic test_branch();
  data_t val;
  test_errs = 0;
  eq_val    = rand64();
  write_ok(dmem_at(30), eq_val);
  write_ok(dmem_at(31), eq_val);
  write_ok(dmem_at(32), ~eq_val);
  prog.delete();
  prog.push_back(encode(OP_LW, 8, 0, 30));
  prog.push_back(encode(OP_LW, 9, 0, 31));
  prog.push_back(encode(OP_LW, 10, 0, 32));
  prog.push_back(encode(OP_CMP, 8, 9, 1));
  prog.push_back(encode(OP_ADD, 11, 8, 0));
  prog.push_back(encode(OP_JA, 8, 10, 2));
  prog.push_back(encode(OP_ADD, 12, 8, 0));
  prog.push_back(encode(OP_HALT, 0, 0, 0));
  load_program();
  start_core();
  wait_stopped();
  read_ok(reg_at(11), val);
  check_data("r11 skipped add", val, '0);
  read_ok(reg_at(12), val);
  check_data("r12 fall-through add", val, eq_val);
  // pc 4 is skipped, the other seven run
  read_ok(ctrl_at(CTRL_RETIRED), val);
  check_data("CTRL_RETIRED", val, data_t'(7));
  finish_test("branch");
endtask

task automatic test_run_ctrl();
  data_t w;
  data_t val;
  logic  err;
  test_errs = 0;
  w = rand64();
  write_ok(dmem_at(50), w);
  prog.delete();
  prog.push_back(encode(OP_ADD, 14, 12, 0));
  // noops mixed with an unused opcode
  for (int k = 0; k < 20; k++) begin
    prog.push_back(encode(k[0] ? opcode_e'(6'b010101) : OP_NOOP, 0, 0, 0));
  end
  prog.push_back(encode(OP_HALT, 0, 0, 0));
  load_program();
  start_core();
  read_ok(ctrl_at(CTRL_RUN), val);
  check_flag("CTRL_RUN while running", val[0], 1'b0);
  apb_read(reg_at(14), val, err);
  check_status("register read while running", err, 1'b1);
  apb_write(dmem_at(50), ~w, err);
  check_status("dmem write while running", err, 1'b1);
  apb_read(imem_at(0), val, err);
  check_status("imem read while running", err, 1'b1);
  wait_stopped();
  read_ok(reg_at(14), val);
  check_data("r14 first run", val, eq_val);
  read_ok(dmem_at(50), val);
  check_data("dmem[50]", val, w);
  // the same accesses succeed once stopped
  read_ok(imem_at(0), val);
  check_word("imem[0] after halt", instr_t'(val[ILEN-1:0]), prog[0]);
  write_ok(dmem_at(50), ~w);
  read_ok(dmem_at(50), val);
  check_data("dmem[50] after halt", val, ~w);
  read_ok(ctrl_at(CTRL_RETIRED), val);
  check_data("CTRL_RETIRED first run", val, data_t'(prog.size()));
  start_core();
  wait_stopped();
  read_ok(reg_at(14), val);
  check_data("r14 second run", val, eq_val + eq_val);
  read_ok(ctrl_at(CTRL_RETIRED), val);
  check_data("CTRL_RETIRED second run", val, data_t'(prog.size()));
  finish_test("run control");
endtask

// ==== tb_top.sv ====
// testbench for cpu_top over APB; the tests run in a fixed order and later ones reuse registers
`timescale 1ns/1ps
`default_nettype none

module tb_top
  import cpu_pkg::*;
();

  localparam int NUM_TESTS  = 5;
  localparam int WAIT_LIMIT = 16;

  logic        clk = 1'b0;
  logic        rst;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic [31:0] lcg_state = 32'd5656;
  int          test_errs;
  int          total_errs;
  int          pass_count;
  int          fail_count;

  cpu_top dut0 (.clk(clk), .rst(rst), .apb_req(apb_req), .apb_rsp(apb_rsp));

  always #4 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic data_t rand64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi, lo};
  endfunction

  // paddr of each region
  function automatic logic [PADDR_W-1:0] ctrl_at(logic [OFFS_W-1:0] off);
    return {REGION_CTRL, off};
  endfunction

  function automatic logic [PADDR_W-1:0] reg_at(int idx);
    return {REGION_REG, OFFS_W'(idx)};
  endfunction

  function automatic logic [PADDR_W-1:0] imem_at(int a);
    return {REGION_IMEM, OFFS_W'(a)};
  endfunction

  function automatic logic [PADDR_W-1:0] dmem_at(int a);
    return {REGION_DMEM, OFFS_W'(a)};
  endfunction

  function automatic void count_error();
    test_errs++;
    total_errs++;
  endfunction

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s got %h expected %h", $time, name, got, exp);
      count_error();
    end
  endtask

  task automatic check_word(input string name, input instr_t got, input instr_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s got %h expected %h", $time, name, got, exp);
      count_error();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s got %b expected %b", $time, name, got, exp);
      count_error();
    end
  endtask

  task automatic check_status(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: pslverr on %s got %b expected %b", $time, name, got, exp);
      count_error();
    end
  endtask

  // setup edge, access edge, then sample at negedge until pready
  task automatic apb_transfer(input logic wr, input logic [PADDR_W-1:0] addr,
                              input data_t wdata, output data_t rdata, output logic err);
    int waits;
    waits = 0;
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    while (!apb_rsp.pready && waits < WAIT_LIMIT) begin
      waits++;
      @(negedge clk);
    end
    if (!apb_rsp.pready) begin
      $display("APB transfer to %h never completed, pready stayed low", addr);
      count_error();
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic apb_write(input logic [PADDR_W-1:0] addr, input data_t wdata,
                           output logic err);
    data_t unused;
    apb_transfer(1'b1, addr, wdata, unused, err);
  endtask

  task automatic apb_read(input logic [PADDR_W-1:0] addr, output data_t rdata,
                          output logic err);
    apb_transfer(1'b0, addr, '0, rdata, err);
  endtask

  task automatic finish_test(input string name);
    if (test_errs == 0) begin
      pass_count++;
      $display("%s test: PASS", name);
    end else begin
      fail_count++;
      $display("%s test: FAIL with %0d errors", name, test_errs);
    end
  endtask

  `include "tb_tests.svh"

  initial begin
    rst        = 1'b1;
    apb_req    = '0;
    test_errs  = 0;
    total_errs = 0;
    pass_count = 0;
    fail_count = 0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    test_reset();
    test_arith();
    test_memory();
    test_branch();
    test_run_ctrl();
    $display("summary: %0d tests pass, %0d tests fail, %0d check errors",
             pass_count, fail_count, total_errs);
    if (total_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(NUM_TESTS * 2000);
    $display("watchdog expired after %0d ns, the tests did not finish", NUM_TESTS * 2000);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
cpu_pkg.sv
word_ram.sv
reg_file.sv
exec_unit.sv
instr_seq.sv
apb_host_port.sv
cpu_top.sv
tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build tb_top with Verilator and run it; exit 0 only when the pass message is printed

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f filelist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_top)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "Test completed successfully"; then
  exit 0
fi
exit 1
